/* files.f */
design/uart_rx_pkg.sv
design/uart_rx_sampler.sv
design/uart_rx_fifo.sv
design/uart_rx_regs.sv
design/uart_rx_top.sv
test/uart_rx_tb.sv

/* Makefile */
# Verilator build and run for the UART receiver testbench.
TOP = uart_rx_tb
OBJ = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --timing --timescale 1ns/10ps \
		-f files.f --top-module $(TOP) -Mdir $(OBJ)

run: compile
	./$(OBJ)/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Some tests failed" sim.log || ! grep -q "All tests passed" sim.log; then \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ) sim.log

/* test/uart_rx_tb.sv */
/*
 Self-checking testbench for the UART receiver.
 Sends serial frames, reads the data and status registers over the bus and
 checks every read and every pulse against a reference byte queue.
*/

`timescale 1ns/10ps
`default_nettype none

module uart_rx_tb;
	localparam int FREQUENCY = 1_600_000;
	localparam int BAUDRATE = 100_000;
	localparam int FIFO_DEPTH = 4;
	localparam int BIT_CYCLES = FREQUENCY / BAUDRATE;
	localparam int CYCLE_LIMIT = 20 * 160 + 2000;

	logic i_clock;
	logic i_reset;
	logic i_rx;
	logic i_request;
	logic [1:0] i_address;
	logic [31:0] o_rdata;
	logic o_ready;
	logic o_interrupt;
	logic o_soft_reset;

	// Reference model state. The compare process owns the head index.
	logic [7:0] model_q[$];
	int model_head = 0;
	int exp_irq = 0;
	int exp_soft = 0;
	int irq_seen = 0;
	int soft_seen = 0;
	int errors = 0;
	int checks = 0;
	int cmp_errors = 0;
	int cmp_checks = 0;
	int cycles = 0;
	logic ready_q;
	logic [31:0] lfsr = 32'hb90f282f;
	logic [7:0] b;

	uart_rx_top #(
		.FREQUENCY(FREQUENCY),
		.BAUDRATE(BAUDRATE),
		.FIFO_DEPTH(FIFO_DEPTH)
	) uut (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_rx(i_rx),
		.i_request(i_request),
		.i_address(i_address),
		.o_rdata(o_rdata),
		.o_ready(o_ready),
		.o_interrupt(o_interrupt),
		.o_soft_reset(o_soft_reset)
	);

	initial begin
		i_clock = 1'b0;
		forever #50 i_clock = ~i_clock;
	end

	// Taps 32, 22, 2, 1.
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [7:0] random_byte();
		logic [7:0] r;
		r = '0;
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsr_next(lfsr);
			r = {lfsr[0], r[7:1]};
		end
		return r;
	endfunction

	// Expected read word for an address from the model queue.
	function automatic uart_rx_pkg::rx_rdata_t expected_word(input logic [1:0] addr);
		uart_rx_pkg::rx_rdata_t w;
		int fill;
		w = '0;
		fill = model_q.size() - model_head;
		if (addr == uart_rx_pkg::ADDR_DATA) begin
			if (fill > 0)
				w.data.value = model_q[model_head];
		end
		else begin
			w.status.full = (fill == FIFO_DEPTH);
			w.status.empty = (fill == 0);
		end
		return w;
	endfunction

	// Good frame seen by the model; a full queue drops it.
	task automatic expect_byte(input logic [7:0] value);
		exp_irq++;
		if (value == uart_rx_pkg::SOFT_RESET_CHAR)
			exp_soft++;
		if (model_q.size() - model_head < FIFO_DEPTH)
			model_q.push_back(value);
	endtask

	task automatic drive_bit(input logic level);
		@(negedge i_clock);
		i_rx = level;
		repeat (BIT_CYCLES - 1) @(negedge i_clock);
	endtask

	task automatic send_frame(input logic [7:0] value, input logic stop_ok);
		drive_bit(1'b0);
		for (int i = 0; i < 8; i++) begin
			drive_bit(value[i]);
		end
		if (stop_ok)
			expect_byte(value);
		drive_bit(stop_ok);
		// Give a false start after a low stop bit time to die out.
		if (!stop_ok) begin
			drive_bit(1'b1);
			drive_bit(1'b1);
		end
	endtask

	task automatic bus_read(input logic [1:0] addr, input int want_latency);
		int latency;
		@(negedge i_clock);
		i_request = 1'b1;
		i_address = addr;
		latency = 0;
		@(posedge i_clock);
		while (!o_ready) begin
			latency++;
			@(posedge i_clock);
		end
		checks++;
		assert (latency == want_latency) else begin
			errors++;
			$display("FAIL o_ready latency: expected %h, got %h", want_latency, latency);
		end
		@(negedge i_clock);
		i_request = 1'b0;
		@(negedge i_clock);
	endtask

	task automatic check_pulses();
		checks++;
		assert (irq_seen == exp_irq) else begin
			errors++;
			$display("FAIL o_interrupt pulses: expected %h, got %h", exp_irq, irq_seen);
		end
		checks++;
		assert (soft_seen == exp_soft) else begin
			errors++;
			$display("FAIL o_soft_reset pulses: expected %h, got %h", exp_soft, soft_seen);
		end
	endtask

	// Pulse counter.
	always @(posedge i_clock) begin
		if (!i_reset && o_interrupt)
			irq_seen++;
		if (!i_reset && o_soft_reset)
			soft_seen++;
	end

	// Compare each completed read with the reference word.
	always @(posedge i_clock) begin
		uart_rx_pkg::rx_rdata_t got;
		uart_rx_pkg::rx_rdata_t want;
		if (i_reset) begin
			ready_q <= 1'b0;
		end
		else begin
			if (o_ready && !ready_q) begin
				got = o_rdata;
				want = expected_word(i_address);
				cmp_checks++;
				if (i_address == uart_rx_pkg::ADDR_DATA) begin
					assert (model_q.size() > model_head) else begin
						cmp_errors++;
						$display("Data read completed although no byte was expected");
					end
					assert (got == want) else begin
						cmp_errors++;
						$display("FAIL o_rdata data: expected %h, got %h",
							want.data.value, got.data.value);
					end
					model_head++;
				end
				else begin
					assert (got == want) else begin
						cmp_errors++;
						$display("FAIL o_rdata status: expected %h, got %h", want, got);
					end
				end
			end
			ready_q <= o_ready;
		end
	end

	// Watchdog.
	initial begin
		while (cycles < CYCLE_LIMIT) begin
			@(posedge i_clock);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("Some tests failed");
		$finish;
	end

	initial begin
		i_reset = 1'b1;
		i_rx = 1'b1;
		i_request = 1'b0;
		i_address = '0;
		repeat (2) @(posedge i_clock);
		@(negedge i_clock);
		i_reset = 1'b0;

		// Idle after reset.
		repeat (40) @(negedge i_clock);
		bus_read(uart_rx_pkg::ADDR_STATUS, 1);
		check_pulses();

		// Three random bytes read back in order.
		repeat (3) begin
			b = random_byte();
			send_frame(b, 1'b1);
		end
		repeat (3) bus_read(uart_rx_pkg::ADDR_DATA, 3);
		bus_read(uart_rx_pkg::ADDR_STATUS, 1);
		check_pulses();

		// Soft-reset character and one ordinary byte.
		send_frame(uart_rx_pkg::SOFT_RESET_CHAR, 1'b1);
		send_frame(8'h5a, 1'b1);
		repeat (20) @(negedge i_clock);
		check_pulses();
		repeat (2) bus_read(uart_rx_pkg::ADDR_DATA, 3);

		// A short glitch and then a frame with a low stop bit.
		@(negedge i_clock);
		i_rx = 1'b0;
		repeat (BIT_CYCLES / 2 - 3) @(negedge i_clock);
		i_rx = 1'b1;
		repeat (2 * BIT_CYCLES) @(negedge i_clock);
		send_frame(random_byte(), 1'b0);
		bus_read(uart_rx_pkg::ADDR_STATUS, 1);
		check_pulses();

		// Overflow leaves only the first four bytes.
		repeat (6) begin
			b = random_byte();
			send_frame(b, 1'b1);
		end
		bus_read(uart_rx_pkg::ADDR_STATUS, 1);
		repeat (4) bus_read(uart_rx_pkg::ADDR_DATA, 3);
		bus_read(uart_rx_pkg::ADDR_STATUS, 1);
		check_pulses();

		// Read from an empty FIFO stalls until a byte arrives.
		@(negedge i_clock);
		i_request = 1'b1;
		i_address = uart_rx_pkg::ADDR_DATA;
		repeat (20) begin
			@(posedge i_clock);
			checks++;
			assert (!o_ready) else begin
				errors++;
				$display("o_ready rose while the FIFO was still empty");
			end
		end
		send_frame(random_byte(), 1'b1);
		@(posedge i_clock);
		while (!o_ready) @(posedge i_clock);
		@(negedge i_clock);
		i_request = 1'b0;
		repeat (4) @(negedge i_clock);
		bus_read(uart_rx_pkg::ADDR_STATUS, 1);
		check_pulses();

		$display("Checks: %0d, errors: %0d", checks + cmp_checks, errors + cmp_errors);
		if (errors + cmp_errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

/* design/uart_rx_top.sv */
/*
 UART receiver with a memory-mapped read port.
 Connects the bit sampler, the receive FIFO and the register port, and
 sets the clock, baud rate and FIFO depth for all of them.
*/

`timescale 1ns/10ps
`default_nettype none

module uart_rx_top #(
	parameter int FREQUENCY = 50_000_000,
	parameter int BAUDRATE = 9600,
	parameter int FIFO_DEPTH = 256
)(
	input wire i_clock,
	input wire i_reset,

	input wire i_rx,

	input wire i_request,
	input wire [1:0] i_address,
	output logic [31:0] o_rdata,
	output logic o_ready,

	output logic o_interrupt,
	output logic o_soft_reset
);
	wire [uart_rx_pkg::DATA_BITS-1:0] rx_byte;
	wire rx_byte_strobe;
	wire fifo_read;
	wire [uart_rx_pkg::DATA_BITS-1:0] fifo_rdata;
	wire fifo_empty;
	wire fifo_full;

	uart_rx_sampler #(
		.FREQUENCY(FREQUENCY),
		.BAUDRATE(BAUDRATE)
	) sampler (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_rx(i_rx),
		.o_byte(rx_byte),
		.o_byte_strobe(rx_byte_strobe),
		.o_interrupt(o_interrupt),
		.o_soft_reset(o_soft_reset)
	);

	uart_rx_fifo #(
		.DEPTH(FIFO_DEPTH),
		.WIDTH(uart_rx_pkg::DATA_BITS)
	) fifo (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_write(rx_byte_strobe),
		.i_wdata(rx_byte),
		.i_read(fifo_read),
		.o_rdata(fifo_rdata),
		.o_empty(fifo_empty),
		.o_full(fifo_full)
	);

	uart_rx_regs regs (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(i_request),
		.i_address(i_address),
		.o_rdata(o_rdata),
		.o_ready(o_ready),
		.o_fifo_read(fifo_read),
		.i_fifo_rdata(fifo_rdata),
		.i_fifo_empty(fifo_empty),
		.i_fifo_full(fifo_full)
	);

endmodule

`default_nettype wire

/* design/uart_rx_regs.sv */
/*
 Bus read port of the UART receiver.
 Address 0 waits for data, pops one byte and returns it; address 1 returns
 the FIFO flags. o_ready holds until the master drops its request.
*/

`timescale 1ns/10ps
`default_nettype none

module uart_rx_regs (
	input wire i_clock,
	input wire i_reset,

	input wire i_request,
	input wire [1:0] i_address,
	output logic [31:0] o_rdata,
	output logic o_ready,

	output logic o_fifo_read,
	input wire [uart_rx_pkg::DATA_BITS-1:0] i_fifo_rdata,
	input wire i_fifo_empty,
	input wire i_fifo_full
);
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_POP,
		ST_LATCH,
		ST_DONE
	} state_t;

	state_t state;
	uart_rx_pkg::rx_rdata_t data_word;
	uart_rx_pkg::rx_rdata_t status_word;

	always_comb begin
		data_word = '0;
		data_word.data.value = i_fifo_rdata;
		status_word = '0;
		status_word.status.full = i_fifo_full;
		status_word.status.empty = i_fifo_empty;
	end

	assign o_fifo_read = (state == ST_POP);
	assign o_ready = (state == ST_DONE) && i_request;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= ST_IDLE;
			o_rdata <= '0;
		end
		else if (!i_request) begin
			state <= ST_IDLE;
		end
		else begin
			case (state)
				ST_IDLE: begin
					if (i_address == uart_rx_pkg::ADDR_DATA && !i_fifo_empty) begin
						state <= ST_POP;
					end
					else if (i_address == uart_rx_pkg::ADDR_STATUS) begin
						o_rdata <= status_word;
						state <= ST_DONE;
					end
				end
				ST_POP: state <= ST_LATCH;
				ST_LATCH: begin
					// Popped byte is on the FIFO output now.
					o_rdata <= data_word;
					state <= ST_DONE;
				end
				default: state <= ST_DONE;
			endcase
		end
	end

	// Only the two defined addresses ever complete.
	a_ready_with_request: assert property (@(posedge i_clock) disable iff (i_reset)
		o_ready |-> i_request && (i_address == uart_rx_pkg::ADDR_DATA ||
			i_address == uart_rx_pkg::ADDR_STATUS));

endmodule

`default_nettype wire

/* design/uart_rx_fifo.sv */
/*
 Synchronous FIFO between the sampler and the register port.
 A write while full is ignored; a read pops the head into a registered output
 that is valid one cycle after the read.
*/

`timescale 1ns/10ps
`default_nettype none

module uart_rx_fifo #(
	parameter int DEPTH = 256,
	parameter int WIDTH = 8
)(
	input wire i_clock,
	input wire i_reset,

	input wire i_write,
	input wire [WIDTH-1:0] i_wdata,

	input wire i_read,
	output logic [WIDTH-1:0] o_rdata,

	output logic o_empty,
	output logic o_full
);
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic do_write;
	logic do_read;

	assign o_empty = (count == '0);
	assign o_full = (count == CNT_W'(DEPTH));

	assign do_write = i_write && !o_full;
	assign do_read = i_read && !o_empty;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else begin
			if (do_write) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_read) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			if (do_write && !do_read) begin
				count <= count + 1'b1;
			end
			else if (do_read && !do_write) begin
				count <= count - 1'b1;
			end
		end
	end

	// Storage and popped word.
	always_ff @(posedge i_clock) begin
		if (do_write) begin
			mem[wr_ptr] <= i_wdata;
		end
		if (do_read) begin
			o_rdata <= mem[rd_ptr];
		end
	end

	a_flags_exclusive: assert property (@(posedge i_clock) disable iff (i_reset)
		!(o_empty && o_full));

	// The reader only pops once it has seen data.
	a_no_read_empty: assert property (@(posedge i_clock) disable iff (i_reset)
		i_read |-> !o_empty);

endmodule

`default_nettype wire

/* design/uart_rx_sampler.sv */
/*
 Serial input side of the UART receiver.
 Synchronizes the line, finds start bits and samples each bit at its middle.
 A byte with a good stop bit is offered to the FIFO with a one-cycle strobe,
 together with the interrupt and, for the soft-reset character, a reset pulse.
*/

`timescale 1ns/10ps
`default_nettype none

module uart_rx_sampler #(
	parameter int FREQUENCY = 50_000_000,
	parameter int BAUDRATE = 9600
)(
	input wire i_clock,
	input wire i_reset,

	input wire i_rx,

	output logic [uart_rx_pkg::DATA_BITS-1:0] o_byte,
	output logic o_byte_strobe,
	output logic o_interrupt,
	output logic o_soft_reset
);
	localparam int BIT_PERIOD = FREQUENCY / BAUDRATE;
	localparam int HALF_BIT = BIT_PERIOD / 2;
	localparam int PRESCALE_W = $clog2(BIT_PERIOD);

	// Bit index runs from the start bit down to the stop bit and rests at zero.
	localparam int FRAME_LEN = uart_rx_pkg::DATA_BITS + 2;
	localparam int IDX_W = $clog2(FRAME_LEN + 1);
	localparam logic [IDX_W-1:0] START_IDX = IDX_W'(FRAME_LEN);
	localparam logic [IDX_W-1:0] STOP_IDX = IDX_W'(1);

	logic rx_meta;
	logic rx_sync;
	logic [PRESCALE_W-1:0] prescale;
	logic [IDX_W-1:0] bidx;
	logic [uart_rx_pkg::DATA_BITS-1:0] shift;

	assign o_byte = shift;

	// Two-flop synchronizer that idles high like the line.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end
		else begin
			rx_meta <= i_rx;
			rx_sync <= rx_meta;
		end
	end

	// Frame sequencing and output pulses.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			prescale <= '0;
			bidx <= '0;
			o_byte_strobe <= 1'b0;
			o_interrupt <= 1'b0;
			o_soft_reset <= 1'b0;
		end
		else begin
			o_byte_strobe <= 1'b0;
			o_interrupt <= 1'b0;
			o_soft_reset <= 1'b0;

			if (prescale != '0) begin
				prescale <= prescale - 1'b1;
			end
			else if (bidx == '0) begin
				// Wait half a bit after the line falls.
				if (!rx_sync) begin
					prescale <= PRESCALE_W'(HALF_BIT - 1);
					bidx <= START_IDX;
				end
			end
			else if (bidx == START_IDX) begin
				if (!rx_sync) begin
					prescale <= PRESCALE_W'(BIT_PERIOD - 1);
					bidx <= bidx - 1'b1;
				end
				else begin
					// Line is high again, so this was a glitch.
					bidx <= '0;
				end
			end
			else if (bidx > STOP_IDX) begin
				prescale <= PRESCALE_W'(BIT_PERIOD - 1);
				bidx <= bidx - 1'b1;
			end
			else begin
				// Stop bit sample; a low stop bit drops the byte.
				bidx <= '0;
				if (rx_sync) begin
					o_byte_strobe <= 1'b1;
					o_interrupt <= 1'b1;
					o_soft_reset <= (shift == uart_rx_pkg::SOFT_RESET_CHAR);
				end
			end
		end
	end

	// Data bits arrive LSB first.
	always_ff @(posedge i_clock) begin
		if (prescale == '0 && bidx > STOP_IDX && bidx < START_IDX) begin
			shift <= {rx_sync, shift[uart_rx_pkg::DATA_BITS-1:1]};
		end
	end

	a_bidx_in_frame: assert property (@(posedge i_clock) disable iff (i_reset)
		bidx <= START_IDX);

endmodule

`default_nettype wire

/* design/uart_rx_pkg.sv */
/*
 Shared definitions for the UART receiver.
 Holds the bus addresses, the frame constants and the read-word layout
 used by the register port and the testbench.
*/

`default_nettype none

package uart_rx_pkg;

	// Bus read addresses.
	localparam logic [1:0] ADDR_DATA = 2'd0;
	localparam logic [1:0] ADDR_STATUS = 2'd1;

	// Frame format.
	localparam int DATA_BITS = 8;
	localparam logic [7:0] SOFT_RESET_CHAR = 8'hff;

	// One read word, decoded as a data byte or as a status word.
	typedef union packed {
		struct packed {
			logic [31-DATA_BITS:0] pad;
			logic [DATA_BITS-1:0] value;
		} data;
		struct packed {
			logic [28:0] pad;
			logic full;
			logic empty;
			logic zero;
		} status;
	} rx_rdata_t;

endpackage

`default_nettype wire
